// File: source/ecc_code_pkg.sv
package ecc_code_pkg;

  localparam int data_width = 64;
  localparam int ecc_width  = 8;
  localparam int code_width = data_width + ecc_width;

  typedef logic [data_width-1:0] data_word_t;
  typedef logic [ecc_width-1:0]  check_t;
  // data in the low bits, check bits on top.
  typedef logic [code_width-1:0] code_word_t;

  // hsiao column of data bit idx.
  // weight-3 values in ascending order, then weight-5 values.
  function automatic check_t h_column(input int idx);
    int     found;
    int     ones;
    check_t col;
    found = 0;
    col   = '0;
    for (int w = 3; w <= 5; w += 2) begin
      for (int v = 0; v < (1 << ecc_width); v++) begin
        ones = 0;
        for (int b = 0; b < ecc_width; b++) begin
          ones += (v >> b) & 1;
        end
        if (ones == w) begin
          if (found == idx) begin
            col = check_t'(v);
          end
          found++;
        end
      end
    end
    return col;
  endfunction

endpackage

// File: source/mc_beat_pkg.sv
package mc_beat_pkg;

  localparam int nck_per_clk    = 2;
  localparam int words_per_beat = 2 * nck_per_clk;
  localparam int addr_width     = 4;
  localparam int store_depth    = 1 << addr_width;
  localparam int count_width    = 16;

  typedef logic [addr_width-1:0]     addr_t;
  typedef logic [words_per_beat-1:0] word_flags_t;
  typedef logic [count_width-1:0]    count_t;

  typedef struct packed {
    ecc_code_pkg::data_word_t [words_per_beat-1:0] word;
  } data_beat_t;

  typedef struct packed {
    ecc_code_pkg::code_word_t [words_per_beat-1:0] word;
  } code_beat_t;

  // one flip mask per code word, set bits get inverted in the store.
  typedef struct packed {
    ecc_code_pkg::code_word_t [words_per_beat-1:0] mask;
  } inject_beat_t;

endpackage

// File: source/ecc_encoder.sv
`timescale 1ns/1ns

module ecc_encoder (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      wr_en,
  input  mc_beat_pkg::addr_t        wr_addr,
  input  mc_beat_pkg::data_beat_t   wr_data,
  input  mc_beat_pkg::inject_beat_t wr_inject,
  output logic                      enc_en,
  output mc_beat_pkg::addr_t        enc_addr,
  output mc_beat_pkg::code_beat_t   enc_code,
  output mc_beat_pkg::inject_beat_t enc_inject
);

  ecc_code_pkg::check_t     h_col    [ecc_code_pkg::data_width];
  ecc_code_pkg::data_word_t h_row    [ecc_code_pkg::ecc_width];
  ecc_code_pkg::check_t     check_ns [mc_beat_pkg::words_per_beat];
  mc_beat_pkg::code_beat_t  code_ns;

  for (genvar n = 0; n < ecc_code_pkg::data_width; n++) begin : g_col
    assign h_col[n] = ecc_code_pkg::h_column(n);
  end

  // transpose columns into parity rows.
  for (genvar m = 0; m < ecc_code_pkg::ecc_width; m++) begin : g_row
    for (genvar n = 0; n < ecc_code_pkg::data_width; n++) begin : g_bit
      assign h_row[m][n] = h_col[n][m];
    end
  end

  always_comb begin
    for (int w = 0; w < mc_beat_pkg::words_per_beat; w++) begin
      for (int m = 0; m < ecc_code_pkg::ecc_width; m++) begin
        check_ns[w][m] = ^(wr_data.word[w] & h_row[m]);
      end
      code_ns.word[w] = {check_ns[w], wr_data.word[w]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      enc_en <= 1'b0;
    end else begin
      enc_en <= wr_en;
    end
  end

  // payload travels with the strobe.
  always_ff @(posedge clk) begin
    enc_addr   <= wr_addr;
    enc_code   <= code_ns;
    enc_inject <= wr_inject;
  end

endmodule

// File: source/ecc_code_store.sv
`timescale 1ns/1ns

module ecc_code_store (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      enc_en,
  input  mc_beat_pkg::addr_t        enc_addr,
  input  mc_beat_pkg::code_beat_t   enc_code,
  input  mc_beat_pkg::inject_beat_t enc_inject,
  input  logic                      rd_en,
  input  mc_beat_pkg::addr_t        rd_addr,
  output logic                      phy_valid,
  output mc_beat_pkg::addr_t        phy_addr,
  output mc_beat_pkg::code_beat_t   phy_code
);

  mc_beat_pkg::code_beat_t mem [mc_beat_pkg::store_depth];
  mc_beat_pkg::code_beat_t wr_beat;

  // faults are applied on the way in, like a bad cell or a bad lane.
  always_comb begin
    for (int w = 0; w < mc_beat_pkg::words_per_beat; w++) begin
      wr_beat.word[w] = enc_code.word[w] ^ enc_inject.mask[w];
    end
  end

  always_ff @(posedge clk) begin
    if (enc_en) begin
      mem[enc_addr] <= wr_beat;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      phy_code <= mem[rd_addr];
      phy_addr <= rd_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      phy_valid <= 1'b0;
    end else begin
      phy_valid <= rd_en;
    end
  end

endmodule

// File: source/ecc_dec_fix.sv
`timescale 1ns/1ns

module ecc_dec_fix (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      phy_valid,
  input  mc_beat_pkg::addr_t        phy_addr,
  input  mc_beat_pkg::code_beat_t   phy_code,
  input  logic                      correct_en,
  output logic                      rd_valid,
  output mc_beat_pkg::addr_t        rd_addr_out,
  output mc_beat_pkg::data_beat_t   rd_data,
  output mc_beat_pkg::word_flags_t  ecc_single,
  output mc_beat_pkg::word_flags_t  ecc_multiple
);

  ecc_code_pkg::check_t     h_col       [ecc_code_pkg::data_width];
  ecc_code_pkg::data_word_t h_row       [ecc_code_pkg::ecc_width];
  ecc_code_pkg::check_t     syndrome_ns [mc_beat_pkg::words_per_beat];
  ecc_code_pkg::check_t     syndrome_r  [mc_beat_pkg::words_per_beat];
  ecc_code_pkg::data_word_t flip_bits   [mc_beat_pkg::words_per_beat];
  mc_beat_pkg::data_beat_t  data_r;

  for (genvar n = 0; n < ecc_code_pkg::data_width; n++) begin : g_col
    assign h_col[n] = ecc_code_pkg::h_column(n);
  end

  for (genvar m = 0; m < ecc_code_pkg::ecc_width; m++) begin : g_row
    for (genvar n = 0; n < ecc_code_pkg::data_width; n++) begin : g_bit
      assign h_row[m][n] = h_col[n][m];
    end
  end

  // check bit m has the unit column, so it just folds into row m.
  always_comb begin
    for (int w = 0; w < mc_beat_pkg::words_per_beat; w++) begin
      for (int m = 0; m < ecc_code_pkg::ecc_width; m++) begin
        syndrome_ns[w][m] =
          ^(phy_code.word[w][ecc_code_pkg::data_width-1:0] & h_row[m]) ^
          phy_code.word[w][ecc_code_pkg::data_width+m];
      end
    end
  end

  always_ff @(posedge clk) begin
    syndrome_r  <= syndrome_ns;
    rd_addr_out <= phy_addr;
    for (int w = 0; w < mc_beat_pkg::words_per_beat; w++) begin
      data_r.word[w] <= phy_code.word[w][ecc_code_pkg::data_width-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= phy_valid;
    end
  end

  // at most one column can match a nonzero syndrome.
  always_comb begin
    for (int w = 0; w < mc_beat_pkg::words_per_beat; w++) begin
      for (int n = 0; n < ecc_code_pkg::data_width; n++) begin
        flip_bits[w][n] = (h_col[n] == syndrome_r[w]);
      end
    end
  end

  always_comb begin
    for (int w = 0; w < mc_beat_pkg::words_per_beat; w++) begin
      if (correct_en) begin
        rd_data.word[w] = data_r.word[w] ^ flip_bits[w];
      end else begin
        rd_data.word[w] = data_r.word[w];
      end
    end
  end

  // odd weight means one flipped bit, even weight means two or more.
  always_comb begin
    for (int w = 0; w < mc_beat_pkg::words_per_beat; w++) begin
      ecc_single[w]   = rd_valid && (|syndrome_r[w]) && (^syndrome_r[w]);
      ecc_multiple[w] = rd_valid && (|syndrome_r[w]) && !(^syndrome_r[w]);
    end
  end

endmodule

// File: source/ecc_err_log.sv
`timescale 1ns/1ns

module ecc_err_log (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     rd_valid,
  input  mc_beat_pkg::addr_t       rd_addr_out,
  input  mc_beat_pkg::word_flags_t ecc_single,
  input  mc_beat_pkg::word_flags_t ecc_multiple,
  output mc_beat_pkg::count_t      single_count,
  output mc_beat_pkg::count_t      multiple_count,
  output logic                     first_multiple_valid,
  output mc_beat_pkg::addr_t       first_multiple_addr
);

  mc_beat_pkg::count_t single_n;
  mc_beat_pkg::count_t multiple_n;
  logic                take_first;

  function automatic mc_beat_pkg::count_t sat_add(input mc_beat_pkg::count_t c,
                                                  input mc_beat_pkg::count_t n);
    logic [mc_beat_pkg::count_width:0] sum;
    sum = {1'b0, c} + {1'b0, n};
    if (sum[mc_beat_pkg::count_width]) begin
      return '1;
    end
    return sum[mc_beat_pkg::count_width-1:0];
  endfunction

  // flagged words in this beat.
  always_comb begin
    single_n   = '0;
    multiple_n = '0;
    if (rd_valid) begin
      for (int w = 0; w < mc_beat_pkg::words_per_beat; w++) begin
        single_n   = single_n + mc_beat_pkg::count_t'(ecc_single[w]);
        multiple_n = multiple_n + mc_beat_pkg::count_t'(ecc_multiple[w]);
      end
    end
  end

  assign take_first = rd_valid && (|ecc_multiple) && !first_multiple_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      single_count         <= '0;
      multiple_count       <= '0;
      first_multiple_valid <= 1'b0;
    end else begin
      single_count   <= sat_add(single_count, single_n);
      multiple_count <= sat_add(multiple_count, multiple_n);
      if (take_first) begin
        first_multiple_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take_first) begin
      first_multiple_addr <= rd_addr_out;
    end
  end

endmodule

// File: source/ecc_datapath.sv
`timescale 1ns/1ns

module ecc_datapath (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      wr_en,
  input  mc_beat_pkg::addr_t        wr_addr,
  input  mc_beat_pkg::data_beat_t   wr_data,
  input  mc_beat_pkg::inject_beat_t wr_inject,
  input  logic                      rd_en,
  input  mc_beat_pkg::addr_t        rd_addr,
  input  logic                      correct_en,
  output logic                      rd_valid,
  output mc_beat_pkg::data_beat_t   rd_data,
  output mc_beat_pkg::word_flags_t  ecc_single,
  output mc_beat_pkg::word_flags_t  ecc_multiple,
  output mc_beat_pkg::count_t       single_count,
  output mc_beat_pkg::count_t       multiple_count,
  output logic                      first_multiple_valid,
  output mc_beat_pkg::addr_t        first_multiple_addr
);

  logic                      enc_en;
  mc_beat_pkg::addr_t        enc_addr;
  mc_beat_pkg::code_beat_t   enc_code;
  mc_beat_pkg::inject_beat_t enc_inject;
  logic                      phy_valid;
  mc_beat_pkg::addr_t        phy_addr;
  mc_beat_pkg::code_beat_t   phy_code;
  mc_beat_pkg::addr_t        rd_addr_out;

  ecc_encoder enc0 (
    .clk, .rst, .wr_en, .wr_addr, .wr_data, .wr_inject,
    .enc_en, .enc_addr, .enc_code, .enc_inject
  );

  // stands in for the dram and phy.
  ecc_code_store store0 (
    .clk, .rst, .enc_en, .enc_addr, .enc_code, .enc_inject,
    .rd_en, .rd_addr,
    .phy_valid, .phy_addr, .phy_code
  );

  ecc_dec_fix dec0 (
    .clk, .rst, .phy_valid, .phy_addr, .phy_code, .correct_en,
    .rd_valid, .rd_addr_out, .rd_data, .ecc_single, .ecc_multiple
  );

  ecc_err_log log0 (
    .clk, .rst, .rd_valid, .rd_addr_out, .ecc_single, .ecc_multiple,
    .single_count, .multiple_count,
    .first_multiple_valid, .first_multiple_addr
  );

endmodule

// File: testbench/ecc_datapath_sva.sv
`timescale 1ns/1ns

module ecc_datapath_sva (
  input logic                     clk,
  input logic                     rst,
  input logic                     rd_en,
  input logic                     rd_valid,
  input mc_beat_pkg::word_flags_t ecc_single,
  input mc_beat_pkg::word_flags_t ecc_multiple,
  input mc_beat_pkg::count_t      single_count,
  input mc_beat_pkg::count_t      multiple_count
);

  // fixed read latency of two cycles.
  valid_latency: assert property (@(posedge clk) disable iff (rst)
    rd_valid == $past(rd_en, 2))
    else $error("rd_valid did not follow rd_en after two cycles");

  flags_idle: assert property (@(posedge clk) disable iff (rst)
    !rd_valid |-> (ecc_single == '0 && ecc_multiple == '0))
    else $error("ecc flags set while rd_valid is low");

  flags_exclusive: assert property (@(posedge clk) disable iff (rst)
    (ecc_single & ecc_multiple) == '0)
    else $error("a word has both the single and the multiple flag");

  // counts saturate, so they only ever move up.
  counts_rise: assert property (@(posedge clk) disable iff (rst)
    single_count >= $past(single_count) && multiple_count >= $past(multiple_count))
    else $error("an error count went down");

endmodule

bind ecc_datapath ecc_datapath_sva sva0 (
  .clk(clk),
  .rst(rst),
  .rd_en(rd_en),
  .rd_valid(rd_valid),
  .ecc_single(ecc_single),
  .ecc_multiple(ecc_multiple),
  .single_count(single_count),
  .multiple_count(multiple_count)
);

// File: testbench/ecc_datapath_tb.sv
`timescale 1ns/1ns

module ecc_datapath_tb;

  localparam int n_rows       = 10;
  localparam int row_cycles   = 6;
  localparam int reset_cycles = 16;
  localparam int clk_period   = 10;
  // table loop, one pipelined re-read per row, and some slack.
  localparam int timeout_ns   = (reset_cycles + n_rows * (row_cycles + 1) + 20) * clk_period * 2;

  typedef enum logic [2:0] {
    inj_none, inj_data, inj_check, inj_two_data, inj_data_check
  } inject_kind_t;

  typedef struct packed {
    mc_beat_pkg::addr_t addr;
    inject_kind_t       kind;
    logic [1:0]         word;
    logic [6:0]         pos_a;
    logic [6:0]         pos_b;
    logic               correct;
  } test_row_t;

  // addr, inject kind, word, first bit, second bit, correct_en.
  // bit positions count in the 72-bit code word with check bits from 64 up.
  test_row_t table_rows [n_rows] = '{
    '{4'h1, inj_none,       2'd0, 7'd0,  7'd0,  1'b1},
    '{4'h2, inj_none,       2'd0, 7'd0,  7'd0,  1'b0},
    '{4'h3, inj_data,       2'd1, 7'd17, 7'd0,  1'b1},
    '{4'h4, inj_data,       2'd2, 7'd63, 7'd0,  1'b0},
    '{4'h5, inj_check,      2'd3, 7'd66, 7'd0,  1'b1},
    '{4'h6, inj_check,      2'd0, 7'd71, 7'd0,  1'b0},
    '{4'h7, inj_two_data,   2'd2, 7'd5,  7'd40, 1'b1},
    '{4'h8, inj_data,       2'd0, 7'd0,  7'd0,  1'b1},
    '{4'h9, inj_data_check, 2'd1, 7'd12, 7'd64, 1'b0},
    '{4'ha, inj_two_data,   2'd3, 7'd62, 7'd63, 1'b0}
  };
  string row_names [n_rows] = '{
    "clean_fix", "clean_raw", "data_fix", "data_raw", "check_fix",
    "check_raw", "double_data", "data_low_fix", "double_mixed", "double_raw"
  };

  logic                      clk;
  logic                      rst;
  logic                      wr_en;
  mc_beat_pkg::addr_t        wr_addr;
  mc_beat_pkg::data_beat_t   wr_data;
  mc_beat_pkg::inject_beat_t wr_inject;
  logic                      rd_en;
  mc_beat_pkg::addr_t        rd_addr;
  logic                      correct_en;
  logic                      rd_valid;
  mc_beat_pkg::data_beat_t   rd_data;
  mc_beat_pkg::word_flags_t  ecc_single;
  mc_beat_pkg::word_flags_t  ecc_multiple;
  mc_beat_pkg::count_t       single_count;
  mc_beat_pkg::count_t       multiple_count;
  logic                      first_multiple_valid;
  mc_beat_pkg::addr_t        first_multiple_addr;

  mc_beat_pkg::data_beat_t   sent_data [n_rows];
  mc_beat_pkg::inject_beat_t sent_mask [n_rows];
  logic [31:0]               lcg_state = 32'd15517;
  int                        model_single = 0;
  int                        model_multiple = 0;
  logic                      model_first_seen = 1'b0;
  mc_beat_pkg::addr_t        model_first_addr = '0;
  int                        checks = 0;
  int                        errors = 0;

  ecc_datapath dut0 (
    .clk, .rst, .wr_en, .wr_addr, .wr_data, .wr_inject, .rd_en, .rd_addr, .correct_en,
    .rd_valid, .rd_data, .ecc_single, .ecc_multiple, .single_count, .multiple_count,
    .first_multiple_valid, .first_multiple_addr
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(timeout_ns);
    $display("timeout, the run did not finish within %0d ns", timeout_ns);
    $display("Something failed");
    $finish;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic mc_beat_pkg::data_beat_t random_beat();
    mc_beat_pkg::data_beat_t beat;
    for (int w = 0; w < mc_beat_pkg::words_per_beat; w++) begin
      lcg_state = lcg_next(lcg_state);
      beat.word[w][63:32] = lcg_state;
      lcg_state = lcg_next(lcg_state);
      beat.word[w][31:0] = lcg_state;
    end
    return beat;
  endfunction

  function automatic logic is_single(input inject_kind_t kind);
    return kind == inj_data || kind == inj_check;
  endfunction

  function automatic logic is_multiple(input inject_kind_t kind);
    return kind == inj_two_data || kind == inj_data_check;
  endfunction

  function automatic mc_beat_pkg::inject_beat_t build_mask(input test_row_t row);
    mc_beat_pkg::inject_beat_t m;
    m = '0;
    if (row.kind != inj_none) begin
      m.mask[row.word][row.pos_a] = 1'b1;
    end
    if (is_multiple(row.kind)) begin
      m.mask[row.word][row.pos_b] = 1'b1;
    end
    return m;
  endfunction

  // a single error is repaired only with correction on; flipped check bits never reach data.
  function automatic mc_beat_pkg::data_beat_t expected_data(input int r, input logic corr);
    mc_beat_pkg::data_beat_t want;
    for (int w = 0; w < mc_beat_pkg::words_per_beat; w++) begin
      want.word[w] = sent_data[r].word[w] ^ sent_mask[r].mask[w][63:0];
    end
    if (corr && is_single(table_rows[r].kind)) begin
      want.word[table_rows[r].word] = sent_data[r].word[table_rows[r].word];
    end
    return want;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic write_row(input int r);
    sent_data[r] = random_beat();
    sent_mask[r] = build_mask(table_rows[r]);
    wr_en = 1'b1;
    wr_addr = table_rows[r].addr;
    wr_data = sent_data[r];
    wr_inject = sent_mask[r];
    next_cycle();
    wr_en = 1'b0;
    wr_inject = '0;
  endtask

  task automatic check_read(input int r, input logic corr, input string phase);
    mc_beat_pkg::data_beat_t  want_data;
    mc_beat_pkg::word_flags_t want_single;
    mc_beat_pkg::word_flags_t want_multiple;
    want_data = expected_data(r, corr);
    want_single = '0;
    want_multiple = '0;
    if (is_single(table_rows[r].kind)) want_single[table_rows[r].word] = 1'b1;
    if (is_multiple(table_rows[r].kind)) want_multiple[table_rows[r].word] = 1'b1;
    checks++;
    assert (rd_valid == 1'b1) else begin
      errors++;
      $display("%s/%s: rd_valid was low two cycles after the read", phase, row_names[r]);
    end
    assert (rd_data == want_data) else begin
      errors++;
      $display("error %s/%s rd_data: expected %h, actual %h", phase, row_names[r],
               want_data, rd_data);
    end
    assert (ecc_single == want_single && ecc_multiple == want_multiple) else begin
      errors++;
      $display("error %s/%s flags: expected %b/%b, actual %b/%b", phase, row_names[r],
               want_single, want_multiple, ecc_single, ecc_multiple);
    end
    model_single += $countones(want_single);
    model_multiple += $countones(want_multiple);
    if (!model_first_seen && want_multiple != '0) begin
      model_first_seen = 1'b1;
      model_first_addr = table_rows[r].addr;
    end
  endtask

  initial begin
    rst = 1'b1;
    wr_en = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    wr_inject = '0;
    rd_en = 1'b0;
    rd_addr = '0;
    correct_en = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;
    next_cycle();
    for (int r = 0; r < n_rows; r++) begin
      write_row(r);
      repeat (3) next_cycle();
      rd_en = 1'b1;
      rd_addr = table_rows[r].addr;
      correct_en = table_rows[r].correct;
      next_cycle();
      rd_en = 1'b0;
      next_cycle();
      check_read(r, table_rows[r].correct, "single");
    end
    // back to back re-reads keep two reads in flight.
    correct_en = 1'b1;
    for (int t = 0; t < n_rows + 2; t++) begin
      if (t >= 2) check_read(t - 2, 1'b1, "stream");
      rd_en = (t < n_rows);
      if (t < n_rows) rd_addr = table_rows[t].addr;
      next_cycle();
    end
    repeat (2) next_cycle();
    checks++;
    assert (single_count == mc_beat_pkg::count_t'(model_single)) else begin
      errors++;
      $display("error totals single_count: expected %0d, actual %0d", model_single,
               single_count);
    end
    assert (multiple_count == mc_beat_pkg::count_t'(model_multiple)) else begin
      errors++;
      $display("error totals multiple_count: expected %0d, actual %0d", model_multiple,
               multiple_count);
    end
    assert (first_multiple_valid == model_first_seen &&
            first_multiple_addr == model_first_addr) else begin
      errors++;
      $display("error totals first_multiple: expected %b/%h, actual %b/%h",
               model_first_seen, model_first_addr, first_multiple_valid,
               first_multiple_addr);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: list.f
source/ecc_code_pkg.sv
source/mc_beat_pkg.sv
source/ecc_encoder.sv
source/ecc_code_store.sv
source/ecc_dec_fix.sv
source/ecc_err_log.sv
source/ecc_datapath.sv
testbench/ecc_datapath_sva.sv
testbench/ecc_datapath_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module ecc_datapath_tb \
  -o ecc_datapath_sim > build.log 2>&1 ||
  { echo "build failed, see build.log"; exit 1; }
./obj_dir/ecc_datapath_sim > sim.log 2>&1
grep -q "^Everything OK$" sim.log &&
  echo "PASS" ||
  { echo "FAIL, see sim.log"; exit 1; }
